// File: design/proc_pkg.sv
package proc_pkg;

   parameter int word_w = 16;

   // Opcode in inst[15:12], codes above HALT are illegal
   typedef enum logic [3:0] {
      NOP  = 4'd0,
      ADD  = 4'd1,
      SUB  = 4'd2,
      AND  = 4'd3,
      OR   = 4'd4,
      ADDI = 4'd5,
      LD   = 4'd6,
      ST   = 4'd7,
      BEQZ = 4'd8,
      HALT = 4'd9
   } opcode_e;

   typedef enum logic [1:0] {
      IDLE,
      LOAD_ACK,
      RUN,
      DONE
   } run_state_e;

   typedef struct packed {
      logic [5:0]        addr;
      logic [word_w-1:0] data;
   } load_word_t;

   typedef struct packed {
      logic              valid;
      logic [word_w-1:0] pc;
      logic [word_w-1:0] inst;
   } fd_reg_t;

   // rt holds the data register index for ST
   typedef struct packed {
      logic              valid;
      opcode_e           op;
      logic [2:0]        rd;
      logic [2:0]        rs;
      logic [2:0]        rt;
      logic              reg_wr;
      logic [word_w-1:0] pc;
      logic [word_w-1:0] a;
      logic [word_w-1:0] b;
      logic [word_w-1:0] imm;
   } dx_reg_t;

   typedef struct packed {
      logic              valid;
      opcode_e           op;
      logic [2:0]        rd;
      logic              reg_wr;
      logic [word_w-1:0] alu_out;
      logic [word_w-1:0] store_data;
   } xm_reg_t;

   typedef struct packed {
      logic              valid;
      opcode_e           op;
      logic [2:0]        rd;
      logic              reg_wr;
      logic [word_w-1:0] wdata;
   } mw_reg_t;

   typedef struct packed {
      logic              wr;
      logic [2:0]        rd;
      logic [word_w-1:0] data;
   } wb_bus_t;

endpackage

// File: design/fetch_stage.sv
`timescale 1ns/100ps

module fetch_stage import proc_pkg::*; #(
   parameter int IMEM_DEPTH = 64
) (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              run,
   input  logic              restart,
   input  logic              stall,
   input  logic              branch_taken,
   input  logic [word_w-1:0] branch_target,
   input  logic              imem_we,
   input  load_word_t        imem_wr,
   output fd_reg_t           fd
);

   localparam int addr_w = $clog2(IMEM_DEPTH);

   logic [word_w-1:0] imem [IMEM_DEPTH];
   logic [word_w-1:0] pc;

   // Host write port, only used while the core is stopped
   always_ff @(posedge clk) begin
      if (imem_we) begin
         imem[imem_wr.addr] <= imem_wr.data;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n || restart) begin
         pc       <= '0;
         fd.valid <= 1'b0;
      end else if (run) begin
         if (branch_taken) begin
            // Redirect and drop the wrong-path fetch
            pc       <= branch_target;
            fd.valid <= 1'b0;
         end else if (!stall) begin
            pc       <= pc + 1'b1;
            fd.valid <= 1'b1;
            fd.pc    <= pc;
            fd.inst  <= imem[pc[addr_w-1:0]];
         end
      end
   end

endmodule

// File: design/decode_stage.sv
`timescale 1ns/100ps

module decode_stage import proc_pkg::*; (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              run,
   input  logic              restart,
   input  logic              flush,
   input  fd_reg_t           fd,
   input  wb_bus_t           wb,
   input  logic              xm_is_load,
   input  logic [2:0]        xm_rd,
   input  logic [2:0]        dbg_sel,
   output dx_reg_t           dx,
   output logic              stall,
   output logic              illegal,
   output logic [word_w-1:0] dbg_data
);

   logic [word_w-1:0] regs [8];
   opcode_e           op;
   logic [2:0]        rd;
   logic [2:0]        rs;
   logic [2:0]        rt;
   logic [word_w-1:0] imm;
   logic [word_w-1:0] rdata_a;
   logic [word_w-1:0] rdata_b;
   logic              legal;
   logic              uses_rs;
   logic              uses_rt;
   logic              reg_wr;
   logic              issue;
   logic              halt_pend;

   assign op  = opcode_e'(fd.inst[15:12]);
   assign rd  = fd.inst[11:9];
   assign rs  = fd.inst[8:6];
   // ST reads its data register from the rd field
   assign rt  = (op == ST) ? fd.inst[11:9] : fd.inst[5:3];
   assign imm = {{(word_w-6){fd.inst[5]}}, fd.inst[5:0]};

   always_comb begin
      legal   = 1'b1;
      uses_rs = 1'b0;
      uses_rt = 1'b0;
      reg_wr  = 1'b0;
      case (op)
         NOP, HALT: ;
         ADD, SUB, AND, OR: begin
            uses_rs = 1'b1;
            uses_rt = 1'b1;
            reg_wr  = 1'b1;
         end
         ADDI, LD: begin
            uses_rs = 1'b1;
            reg_wr  = 1'b1;
         end
         ST: begin
            uses_rs = 1'b1;
            uses_rt = 1'b1;
         end
         BEQZ: uses_rs = 1'b1;
         default: legal = 1'b0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         for (int i = 0; i < 8; i++) begin
            regs[i] <= '0;
         end
      end else if (wb.wr) begin
         regs[wb.rd] <= wb.data;
      end
   end

   // Write-before-read, a value retiring in W is visible here
   assign rdata_a  = (wb.wr && wb.rd == rs) ? wb.data : regs[rs];
   assign rdata_b  = (wb.wr && wb.rd == rt) ? wb.data : regs[rt];
   assign dbg_data = regs[dbg_sel];

   // Load in X feeding this instruction, hold one cycle
   assign stall = fd.valid && xm_is_load &&
                  ((uses_rs && rs == xm_rd) || (uses_rt && rt == xm_rd));

   assign issue   = fd.valid && !flush && !stall && !halt_pend;
   assign illegal = fd.valid && !flush && !halt_pend && !legal;

   always_ff @(posedge clk) begin
      if (!rst_n || restart) begin
         dx.valid  <= 1'b0;
         halt_pend <= 1'b0;
      end else if (run) begin
         dx.valid  <= issue && legal;
         // Nothing behind a HALT enters X
         if (issue && op == HALT) begin
            halt_pend <= 1'b1;
         end
         dx.op     <= op;
         dx.rd     <= rd;
         dx.rs     <= rs;
         dx.rt     <= rt;
         dx.reg_wr <= reg_wr;
         dx.pc     <= fd.pc;
         dx.a      <= rdata_a;
         dx.b      <= rdata_b;
         dx.imm    <= imm;
      end
   end

   // Writeback only happens in cycles where the core is running
   a_wb_in_run: assert property (@(posedge clk) disable iff (!rst_n) wb.wr |-> run);

endmodule

// File: design/execute_stage.sv
`timescale 1ns/100ps

module execute_stage import proc_pkg::*; (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              run,
   input  logic              restart,
   input  dx_reg_t           dx,
   input  wb_bus_t           mw_fwd,
   output xm_reg_t           xm,
   output logic              branch_taken,
   output logic [word_w-1:0] branch_target,
   output logic              xm_is_load,
   output logic [2:0]        xm_rd
);

   logic [word_w-1:0] op_a;
   logic [word_w-1:0] op_b;
   logic [word_w-1:0] alu_out;

   // Youngest producer wins: X/M, then M/W, then the register file
   function automatic logic [word_w-1:0] fwd_sel(
      input logic [2:0]        src,
      input logic [word_w-1:0] rf_val,
      input xm_reg_t           x,
      input wb_bus_t           w
   );
      if (x.valid && x.reg_wr && x.rd == src) begin
         return x.alu_out;
      end else if (w.wr && w.rd == src) begin
         return w.data;
      end
      return rf_val;
   endfunction

   assign op_a = fwd_sel(dx.rs, dx.a, xm, mw_fwd);
   assign op_b = fwd_sel(dx.rt, dx.b, xm, mw_fwd);

   always_comb begin
      case (dx.op)
         ADD:          alu_out = op_a + op_b;
         SUB:          alu_out = op_a - op_b;
         AND:          alu_out = op_a & op_b;
         OR:           alu_out = op_a | op_b;
         ADDI, LD, ST: alu_out = op_a + dx.imm;
         default:      alu_out = '0;
      endcase
   end

   assign branch_taken  = dx.valid && dx.op == BEQZ && op_a == '0;
   assign branch_target = dx.pc + 1'b1 + dx.imm;

   // Load currently in X, used by decode for the load-use check
   assign xm_is_load = dx.valid && dx.op == LD;
   assign xm_rd      = dx.rd;

   always_ff @(posedge clk) begin
      if (!rst_n || restart) begin
         xm.valid <= 1'b0;
      end else if (run) begin
         xm.valid      <= dx.valid;
         xm.op         <= dx.op;
         xm.rd         <= dx.rd;
         xm.reg_wr     <= dx.reg_wr;
         xm.alu_out    <= alu_out;
         xm.store_data <= op_b;
      end
   end

   // A taken branch leaves a bubble in D/X behind it
   a_branch_valid: assert property (@(posedge clk) disable iff (!rst_n)
      run && branch_taken |=> !dx.valid);

endmodule

// File: design/memory_stage.sv
`timescale 1ns/100ps

module memory_stage import proc_pkg::*; #(
   parameter int DMEM_DEPTH = 64
) (
   input  logic    clk,
   input  logic    rst_n,
   input  logic    run,
   input  logic    restart,
   input  xm_reg_t xm,
   output wb_bus_t wb,
   output logic    halted
);

   localparam int addr_w = $clog2(DMEM_DEPTH);

   logic [word_w-1:0] dmem [DMEM_DEPTH];
   logic [word_w-1:0] rdata;
   mw_reg_t           mw;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         for (int i = 0; i < DMEM_DEPTH; i++) begin
            dmem[i] <= '0;
         end
      end else if (run && xm.valid && xm.op == ST) begin
         dmem[xm.alu_out[addr_w-1:0]] <= xm.store_data;
      end
   end

   // Read data lines up with mw
   always_ff @(posedge clk) begin
      if (run) begin
         rdata <= dmem[xm.alu_out[addr_w-1:0]];
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n || restart) begin
         mw.valid <= 1'b0;
      end else if (run) begin
         mw.valid  <= xm.valid;
         mw.op     <= xm.op;
         mw.rd     <= xm.rd;
         mw.reg_wr <= xm.reg_wr;
         mw.wdata  <= xm.alu_out;
      end
   end

   assign wb.wr   = run && mw.valid && mw.reg_wr;
   assign wb.rd   = mw.rd;
   assign wb.data = (mw.op == LD) ? rdata : mw.wdata;
   assign halted  = mw.valid && mw.op == HALT;

endmodule

// File: design/run_control.sv
`timescale 1ns/100ps

module run_control import proc_pkg::*; (
   input  logic       clk,
   input  logic       rst_n,
   input  logic       load_req,
   input  load_word_t load,
   input  logic       start,
   input  logic       halted,
   input  logic       illegal,
   input  logic       expired,
   output logic       load_ack,
   output logic       imem_we,
   output load_word_t imem_wr,
   output logic       run,
   output logic       restart,
   output logic       done,
   output logic       err
);

   run_state_e state;
   run_state_e state_nxt;
   logic       stopped;

   assign stopped  = (state == IDLE) || (state == DONE);
   assign imem_we  = stopped && load_req;
   assign imem_wr  = load;
   assign restart  = stopped && start && !load_req;
   assign load_ack = (state == LOAD_ACK);
   assign run      = (state == RUN);

   always_comb begin
      state_nxt = state;
      case (state)
         IDLE, DONE: begin
            if (load_req) begin
               state_nxt = LOAD_ACK;
            end else if (start) begin
               state_nxt = RUN;
            end
         end
         // Hold ack until the host lets go of req
         LOAD_ACK: if (!load_req) state_nxt = IDLE;
         RUN:      if (halted || illegal || expired) state_nxt = DONE;
         default:  state_nxt = IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state <= IDLE;
         done  <= 1'b0;
         err   <= 1'b0;
      end else begin
         state <= state_nxt;
         if (restart) begin
            done <= 1'b0;
            err  <= 1'b0;
         end else if (run && state_nxt == DONE) begin
            done <= 1'b1;
            // Clean HALT wins over a same-cycle error
            err  <= !halted;
         end
      end
   end

   a_no_ack_in_run: assert property (@(posedge clk) disable iff (!rst_n)
      load_ack |-> !run && $past(!run));

   a_we_one_pulse: assert property (@(posedge clk) disable iff (!rst_n)
      imem_we |=> !imem_we && load_ack);

endmodule

// File: design/cycle_counter.sv
`timescale 1ns/100ps

module cycle_counter import proc_pkg::*; #(
   parameter int MAX_CYCLES = 1024
) (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              run,
   input  logic              restart,
   output logic [word_w-1:0] cycles,
   output logic              expired
);

   localparam logic [word_w-1:0] limit = word_w'(MAX_CYCLES);

   // Stops at the limit, so a runaway program reports exactly MAX_CYCLES
   assign expired = (cycles >= limit);

   always_ff @(posedge clk) begin
      if (!rst_n || restart) begin
         cycles <= '0;
      end else if (run && !expired) begin
         cycles <= cycles + 1'b1;
      end
   end

endmodule

// File: design/proc.sv
`timescale 1ns/100ps

module proc import proc_pkg::*; #(
   parameter int IMEM_DEPTH = 64,
   parameter int DMEM_DEPTH = 64,
   parameter int MAX_CYCLES = 1024
) (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              load_req,
   input  load_word_t        load,
   input  logic              start,
   input  logic [2:0]        dbg_sel,
   output logic              load_ack,
   output logic              done,
   output logic              err,
   output logic [word_w-1:0] cycles,
   output logic [word_w-1:0] dbg_data
);

   load_word_t        imem_wr;
   logic              imem_we;
   logic              run;
   logic              restart;
   logic              stall;
   logic              illegal;
   logic              halted;
   logic              expired;
   logic              branch_taken;
   logic [word_w-1:0] branch_target;
   logic              xm_is_load;
   logic [2:0]        xm_rd;
   fd_reg_t           fd;
   dx_reg_t           dx;
   xm_reg_t           xm;
   wb_bus_t           wb;

   run_control i_run_control (.clk(clk), .rst_n(rst_n), .load_req(load_req), .load(load),
      .start(start), .halted(halted), .illegal(illegal), .expired(expired),
      .load_ack(load_ack), .imem_we(imem_we), .imem_wr(imem_wr), .run(run),
      .restart(restart), .done(done), .err(err));

   cycle_counter #(.MAX_CYCLES(MAX_CYCLES)) i_cycle_counter (.clk(clk), .rst_n(rst_n),
      .run(run), .restart(restart), .cycles(cycles), .expired(expired));

   fetch_stage #(.IMEM_DEPTH(IMEM_DEPTH)) i_fetch (.clk(clk), .rst_n(rst_n), .run(run),
      .restart(restart), .stall(stall), .branch_taken(branch_taken),
      .branch_target(branch_target), .imem_we(imem_we), .imem_wr(imem_wr), .fd(fd));

   // Taken branch in X flushes the instruction in D
   decode_stage i_decode (.clk(clk), .rst_n(rst_n), .run(run), .restart(restart),
      .flush(branch_taken), .fd(fd), .wb(wb), .xm_is_load(xm_is_load), .xm_rd(xm_rd),
      .dbg_sel(dbg_sel), .dx(dx), .stall(stall), .illegal(illegal), .dbg_data(dbg_data));

   execute_stage i_execute (.clk(clk), .rst_n(rst_n), .run(run), .restart(restart),
      .dx(dx), .mw_fwd(wb), .xm(xm), .branch_taken(branch_taken),
      .branch_target(branch_target), .xm_is_load(xm_is_load), .xm_rd(xm_rd));

   memory_stage #(.DMEM_DEPTH(DMEM_DEPTH)) i_memory (.clk(clk), .rst_n(rst_n), .run(run),
      .restart(restart), .xm(xm), .wb(wb), .halted(halted));

endmodule

// File: bench/tb_clock.sv
`timescale 1ns/100ps

module tb_clock #(
   parameter int PERIOD_NS    = 40,
   parameter int RESET_CYCLES = 4
) (
   output logic clk,
   output logic rst_n
);

   initial begin
      clk = 1'b0;
      forever #(PERIOD_NS / 2) clk = ~clk;
   end

   // Reset is released on a falling edge like every other input
   initial begin
      rst_n = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
   end

endmodule

// File: bench/proc_tb.sv
`timescale 1ns/100ps

module proc_tb import proc_pkg::*; ();

   localparam int MAX_CYCLES = 1024;
   localparam int TIMEOUT    = 2000;

   logic              clk;
   logic              rst_n;
   logic              load_req;
   load_word_t        load;
   logic              start;
   logic [2:0]        dbg_sel;
   logic              load_ack;
   logic              done;
   logic              err;
   logic [word_w-1:0] cycles;
   logic [word_w-1:0] dbg_data;

   integer            seed = 32'h510a164f;
   integer            fh;
   integer            code;
   integer            num;
   integer            reg_idx;
   logic [5:0]        wr_addr;
   logic [15:0]       word;
   logic [15:0]       value;
   logic [8*16-1:0]   cmd;
   logic [8*16-1:0]   name;
   logic [8*24-1:0]   label;
   logic [8*128-1:0]  line;

   tb_clock #(.PERIOD_NS(40), .RESET_CYCLES(4)) i_clock (.clk(clk), .rst_n(rst_n));

   proc #(.IMEM_DEPTH(64), .DMEM_DEPTH(64), .MAX_CYCLES(MAX_CYCLES)) i_proc (
      .clk(clk), .rst_n(rst_n), .load_req(load_req), .load(load), .start(start),
      .dbg_sel(dbg_sel), .load_ack(load_ack), .done(done), .err(err), .cycles(cycles),
      .dbg_data(dbg_data));

   task automatic check(input logic [8*24-1:0] test, input logic [31:0] expected,
                        input logic [31:0] actual);
      if (expected !== actual) begin
         $display("FAILED %0s: expected %0h, actual %0h", test, expected, actual);
         $display("TB FAILED");
         $fatal(1, "value mismatch");
      end
   endtask

   task automatic abort(input logic [8*48-1:0] what);
      $display("ERROR: %0s", what);
      $display("TB FAILED");
      $fatal(1, "testbench stopped");
   endtask

   task automatic wait_ack(input logic level);
      int n;
      n = 0;
      while (load_ack !== level) begin
         @(negedge clk);
         n++;
         if (n > TIMEOUT) begin
            abort("load_ack did not change in time");
         end
      end
   endtask

   // Four-phase write of one instruction word, called on a falling edge
   task automatic load_word(input logic [5:0] addr, input logic [15:0] data);
      check("ack idle before req", 1'b0, load_ack);
      load.addr = addr;
      load.data = data;
      load_req  = 1'b1;
      wait_ack(1'b1);
      // Ack has to stay up while req is held
      @(negedge clk);
      check("ack held with req", 1'b1, load_ack);
      load_req = 1'b0;
      wait_ack(1'b0);
   endtask

   task automatic run_prog(input logic [8*16-1:0] test, input logic exp_err,
                           input int exp_cycles, input logic hold_req);
      int n;
      n = 0;
      start = 1'b1;
      @(negedge clk);
      start = 1'b0;
      check("done cleared by start", 1'b0, done);
      // A request raised in RUN must wait for done
      if (hold_req) begin
         load.addr = 6'd63;
         load.data = 16'h0000;
         load_req  = 1'b1;
      end
      while (done !== 1'b1) begin
         if (hold_req) begin
            check("ack held off in run", 1'b0, load_ack);
         end
         @(negedge clk);
         n++;
         if (n > TIMEOUT) begin
            abort("done did not rise in time");
         end
      end
      check(test, exp_err, err);
      if (exp_cycles != 0) begin
         check(test, exp_cycles, cycles);
      end
      if (hold_req) begin
         check("ack held off at done", 1'b0, load_ack);
         wait_ack(1'b1);
         load_req = 1'b0;
         wait_ack(1'b0);
      end
   endtask

   task automatic read_reg(input int idx, output logic [15:0] data);
      dbg_sel = idx[2:0];
      @(negedge clk);
      data = dbg_data;
   endtask

   // Dependent ADDI chain into rd, first link starts from r0
   task automatic random_chain(input int rd, input int count);
      logic [31:0] rnd;
      logic [5:0]  imm;
      logic [2:0]  rs;
      logic [15:0] expected;
      logic [15:0] result;
      expected = '0;
      for (int i = 0; i < count; i++) begin
         rnd      = $random(seed);
         imm      = rnd[5:0];
         rs       = (i == 0) ? 3'd0 : rd[2:0];
         expected = expected + {{10{imm[5]}}, imm};
         load_word(i[5:0], {4'h5, rd[2:0], rs, imm});
      end
      load_word(count[5:0], 16'h9000);
      run_prog("random chain", 1'b0, count + 5, 1'b0);
      read_reg(rd, result);
      check("random chain", expected, result);
   endtask

   initial begin
      int n;
      load_req = 1'b0;
      load     = '0;
      start    = 1'b0;
      dbg_sel  = '0;
      wr_addr  = '0;
      name     = "none";
      n        = 0;
      fh = $fopen("bench/proc_patterns.txt", "r");
      if (fh == 0) begin
         abort("cannot open bench/proc_patterns.txt");
      end
      while (rst_n !== 1'b1) begin
         @(negedge clk);
         n++;
         if (n > TIMEOUT) begin
            abort("reset was never released");
         end
      end
      @(negedge clk);
      check("reset outputs", 3'b000, {load_ack, done, err});
      check("reset cycles", 16'd0, cycles);

      while ($fscanf(fh, "%s", cmd) == 1) begin
         if (cmd == "#") begin
            code = $fgets(line, fh);
         end else if (cmd == "w") begin
            code = $fscanf(fh, "%h", word);
            load_word(wr_addr, word);
            wr_addr = wr_addr + 1'b1;
         end else if (cmd == "r" || cmd == "h" || cmd == "e") begin
            code = $fscanf(fh, "%s %d", name, num);
            run_prog(name, cmd == "e", num, cmd == "h");
            wr_addr = '0;
         end else if (cmd == "c") begin
            code = $fscanf(fh, "%d %h", reg_idx, word);
            read_reg(reg_idx, value);
            $sformat(label, "%0s r%0d", name, reg_idx);
            check(label, word, value);
         end else if (cmd == "x") begin
            code = $fscanf(fh, "%d %d", reg_idx, num);
            random_chain(reg_idx, num);
         end else begin
            abort("unknown command in pattern file");
         end
      end
      $fclose(fh);
      $display("TB PASSED");
      $finish;
   end

endmodule

// File: build.f
design/proc_pkg.sv
design/fetch_stage.sv
design/decode_stage.sv
design/execute_stage.sv
design/memory_stage.sv
design/run_control.sv
design/cycle_counter.sv
design/proc.sv
bench/tb_clock.sv
bench/proc_tb.sv

// File: Bender.yml
package:
  name: proc

sources:
  - design/proc_pkg.sv
  - design/fetch_stage.sv
  - design/decode_stage.sv
  - design/execute_stage.sv
  - design/memory_stage.sv
  - design/run_control.sv
  - design/cycle_counter.sv
  - design/proc.sv
  - target: simulation
    files:
      - bench/tb_clock.sv
      - bench/proc_tb.sv

// File: bench/proc_patterns.txt
# w <hex word> | r <name> <cycles> | h <name> <cycles> (load_req held) | e <name> <cycles, 0 skips>
# c <reg> <hex value> | x <reg> <count> (random ADDI chain)
w 5205
w 5443
w 1650
w 28c8
w 3ae0
w 4d48
w 5fbe
w 2238
w 9000
r arith 13
c 1 fff5
c 3 000d
c 4 0008
c 7 000b
w 5215
w 5404
w 7282
w 6682
w 18c8
w 9000
r memld 11
c 3 0015
c 4 002a
w 5201
w 8002
w 5250
w 5250
w 8041
w 5407
w 9000
h branch 11
c 1 0001
c 2 0007
w 5403
w f000
w 9000
e illegal 0
w 803f
w 0000
e watchdog 1024
x 3 12
x 5 20
